/* design/ttlBusPkg.sv */
package ttlBusPkg;

  // Host side of the legacy TTL memory bus
  localparam int TtlAddrWidth = 16;
  localparam int TtlDataWidth = 8;

  // Command opcode carried in the top bit of a FIFO entry
  typedef enum logic {
    OpRead  = 1'b0,
    OpWrite = 1'b1
  } cmdOp_t;

  // FIFO entry layout, MSB first: opcode, host address, write byte
  localparam int CmdAddrLsb = TtlDataWidth;
  localparam int CmdOpBit   = TtlAddrWidth + TtlDataWidth;
  localparam int CmdWidth   = CmdOpBit + 1;

  // Front end FSM
  typedef enum logic [2:0] {
    Idle,
    Accept,
    ReadWait,
    ReadHold,
    Release
  } frontState_t;

endpackage

/* design/mstBusPkg.sv */
package mstBusPkg;

  // IPIF master side, single-beat word bus
  localparam int MstAddrWidth = 32;
  localparam int MstDataWidth = 32;
  localparam int MstBeWidth   = MstDataWidth / 8;
  localparam int LaneWidth    = $clog2(MstBeWidth);

  // Command FIFO sizing, depth must be a power of two
  localparam int FifoDepth    = 4;
  localparam int FifoPtrWidth = $clog2(FifoDepth);
  localparam int FifoCntWidth = FifoPtrWidth + 1;

  // Master engine FSM
  typedef enum logic [1:0] {
    Idle,
    Request,
    Complete,
    Respond
  } mstState_t;

endpackage

/* design/ttlBusFrontend.sv */
`timescale 1ns/1ps

module ttlBusFrontend (
  input  logic                                bus2ip_clk,
  input  logic                                rst_n,
  input  logic                                enable,
  input  logic                                nChipEnable,
  input  logic                                nOutputEnable,
  input  logic                                nWriteEnable,
  input  logic [ttlBusPkg::TtlAddrWidth-1:0]  address,
  input  logic [ttlBusPkg::TtlDataWidth-1:0]  dataIn,
  input  logic                                cmdFull,
  input  logic                                rdValid,
  input  logic [ttlBusPkg::TtlDataWidth-1:0]  rdData,
  output logic                                nWait,
  output logic [ttlBusPkg::TtlDataWidth-1:0]  dataOut,
  output logic                                dataOe,
  output logic                                cmdPush,
  output logic [ttlBusPkg::CmdWidth-1:0]      cmdIn
);
  import ttlBusPkg::*;

  logic [1:0] ceSync;
  logic [1:0] oeSync;
  logic [1:0] weSync;
  logic ceActive;
  logic wrStrobe;
  logic rdStrobe;
  logic strobeReq;
  logic takeCmd;
  logic dataValid;
  logic [TtlDataWidth-1:0] readData;
  frontState_t state;

  // Host strobes are asynchronous, two flops each
  always_ff @(posedge bus2ip_clk) begin
    if (!rst_n) begin
      ceSync <= 2'b11;
      oeSync <= 2'b11;
      weSync <= 2'b11;
    end else begin
      ceSync <= {ceSync[0], nChipEnable};
      oeSync <= {oeSync[0], nOutputEnable};
      weSync <= {weSync[0], nWriteEnable};
    end
  end

  assign ceActive  = ~ceSync[1];
  // Write wins when both enables are low
  assign wrStrobe  = ceActive & ~weSync[1];
  assign rdStrobe  = ceActive & ~oeSync[1] & weSync[1];
  assign strobeReq = wrStrobe | rdStrobe;

  // A new strobe is taken only from Idle with enable set, or from the stall
  assign takeCmd = strobeReq && !cmdFull &&
                   ((state == Idle && enable) || state == Accept);

  always_ff @(posedge bus2ip_clk) begin
    if (!rst_n) begin
      state     <= Idle;
      cmdPush   <= 1'b0;
      nWait     <= 1'b1;
      dataValid <= 1'b0;
    end else begin
      cmdPush <= takeCmd;
      case (state)
        Idle: begin
          if (enable && strobeReq) begin
            // Writes are posted, reads and stalls hold the host
            nWait <= wrStrobe & ~cmdFull;
            if (cmdFull) begin
              state <= Accept;
            end else begin
              state <= wrStrobe ? Release : ReadWait;
            end
          end
        end
        Accept: begin
          if (!strobeReq) begin
            nWait <= 1'b1;
            state <= Idle;
          end else if (!cmdFull) begin
            nWait <= wrStrobe;
            state <= wrStrobe ? Release : ReadWait;
          end
        end
        ReadWait: begin
          if (rdValid) begin
            dataValid <= 1'b1;
            nWait     <= 1'b1;
            state     <= ReadHold;
          end
        end
        ReadHold: begin
          // Keep the byte until the host lets go of the output enable
          if (ceSync[1] || oeSync[1]) begin
            dataValid <= 1'b0;
            state     <= Release;
          end
        end
        Release: begin
          if (!strobeReq) begin
            state <= Idle;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  always_ff @(posedge bus2ip_clk) begin
    if (takeCmd) begin
      cmdIn <= {wrStrobe ? OpWrite : OpRead, address, dataIn};
    end
    if (state == ReadWait && rdValid) begin
      readData <= rdData;
    end
  end

  assign dataOut = readData;
  // Raw strobes so the driver turns off as soon as the host releases
  assign dataOe  = dataValid & ~nChipEnable & ~nOutputEnable;

  pushNotFull: assert property (@(posedge bus2ip_clk) disable iff (!rst_n)
    cmdPush |-> !cmdFull);

  noDriveOnWrite: assert property (@(posedge bus2ip_clk) disable iff (!rst_n)
    dataOe |-> nWriteEnable);

endmodule

/* design/cmdFifo.sv */
`timescale 1ns/1ps

module cmdFifo (
  input  logic                            bus2ip_clk,
  input  logic                            rst_n,
  input  logic                            cmdPush,
  input  logic [ttlBusPkg::CmdWidth-1:0]  cmdIn,
  input  logic                            cmdPop,
  output logic [ttlBusPkg::CmdWidth-1:0]  cmdOut,
  output logic                            cmdFull,
  output logic                            cmdEmpty
);
  import ttlBusPkg::*;
  import mstBusPkg::*;

  logic [CmdWidth-1:0] mem [FifoDepth];
  logic [FifoPtrWidth-1:0] wrPtr;
  logic [FifoPtrWidth-1:0] rdPtr;
  logic [FifoCntWidth-1:0] count;
  logic [FifoCntWidth-1:0] countNext;
  logic doPush;
  logic doPop;

  assign doPush = cmdPush & ~cmdFull;
  assign doPop  = cmdPop & ~cmdEmpty;

  always_comb begin
    countNext = count;
    if (doPush && !doPop) begin
      countNext = count + 1'b1;
    end else if (doPop && !doPush) begin
      countNext = count - 1'b1;
    end
  end

  always_ff @(posedge bus2ip_clk) begin
    if (doPush) begin
      mem[wrPtr] <= cmdIn;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge bus2ip_clk) begin
    if (!rst_n) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      count    <= '0;
      cmdFull  <= 1'b0;
      cmdEmpty <= 1'b1;
    end else begin
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      count    <= countNext;
      cmdFull  <= (countNext == FifoCntWidth'(FifoDepth));
      cmdEmpty <= (countNext == '0);
    end
  end

  // Head entry straight from storage, a new entry shows up after its write
  assign cmdOut = mem[rdPtr];

  noPopEmpty: assert property (@(posedge bus2ip_clk) disable iff (!rst_n)
    cmdPop |-> !cmdEmpty);

endmodule

/* design/ipifMasterEngine.sv */
`timescale 1ns/1ps

module ipifMasterEngine (
  input  logic                                bus2ip_clk,
  input  logic                                rst_n,
  input  logic [ttlBusPkg::CmdWidth-1:0]      cmdOut,
  input  logic                                cmdEmpty,
  input  logic [mstBusPkg::MstAddrWidth-1:0]  mappedAddress,
  input  logic                                bus2ipMstCmdack,
  input  logic                                bus2ipMstCmplt,
  input  logic                                bus2ipMstError,
  input  logic [mstBusPkg::MstDataWidth-1:0]  bus2ipMstrdD,
  output logic                                cmdPop,
  output logic                                ip2busMstRdReq,
  output logic                                ip2busMstWrReq,
  output logic [mstBusPkg::MstAddrWidth-1:0]  ip2busMstAddr,
  output logic [mstBusPkg::MstBeWidth-1:0]    ip2busMstBe,
  output logic [mstBusPkg::MstDataWidth-1:0]  ip2busMstWrD,
  output logic                                rdValid,
  output logic [ttlBusPkg::TtlDataWidth-1:0]  rdData,
  output logic                                mstError
);
  import ttlBusPkg::*;
  import mstBusPkg::*;

  cmdOp_t cmdOp;
  cmdOp_t curOp;
  logic [TtlAddrWidth-1:0] cmdAddr;
  logic [TtlDataWidth-1:0] cmdData;
  logic [LaneWidth-1:0] cmdLane;
  logic [LaneWidth-1:0] lane;
  logic done;
  mstState_t state;

  // Split the FIFO head into its fields
  assign cmdOp   = cmdOp_t'(cmdOut[CmdOpBit]);
  assign cmdAddr = cmdOut[CmdAddrLsb +: TtlAddrWidth];
  assign cmdData = cmdOut[TtlDataWidth-1:0];
  assign cmdLane = cmdAddr[LaneWidth-1:0];

  // Idle also names a front end state, hence the scoped name here
  assign cmdPop = (state == mstBusPkg::Idle) && !cmdEmpty;

  // Completion may land in the same cycle as the command acknowledge
  assign done = bus2ipMstCmplt &&
                (state == Complete || (state == Request && bus2ipMstCmdack));

  assign rdValid = (state == Respond);

  always_ff @(posedge bus2ip_clk) begin
    if (!rst_n) begin
      state          <= mstBusPkg::Idle;
      ip2busMstRdReq <= 1'b0;
      ip2busMstWrReq <= 1'b0;
      mstError       <= 1'b0;
    end else begin
      case (state)
        mstBusPkg::Idle: begin
          if (cmdPop) begin
            ip2busMstRdReq <= (cmdOp == OpRead);
            ip2busMstWrReq <= (cmdOp == OpWrite);
            state          <= Request;
          end
        end
        Request: begin
          if (bus2ipMstCmdack) begin
            ip2busMstRdReq <= 1'b0;
            ip2busMstWrReq <= 1'b0;
            state          <= Complete;
          end
        end
        Complete: begin
        end
        Respond: begin
          state <= mstBusPkg::Idle;
        end
        default: state <= mstBusPkg::Idle;
      endcase

      if (done) begin
        state <= (curOp == OpRead) ? Respond : mstBusPkg::Idle;
        // Sticky until reset
        if (bus2ipMstError) begin
          mstError <= 1'b1;
        end
      end
    end
  end

  // Request payload, held until the next pop
  always_ff @(posedge bus2ip_clk) begin
    if (cmdPop) begin
      curOp         <= cmdOp;
      lane          <= cmdLane;
      ip2busMstAddr <= mappedAddress + MstAddrWidth'(cmdAddr);
      ip2busMstBe   <= MstBeWidth'(1) << cmdLane;
      ip2busMstWrD  <= MstDataWidth'(cmdData) << (TtlDataWidth * cmdLane);
    end
    if (done) begin
      rdData <= bus2ipMstrdD[TtlDataWidth * lane +: TtlDataWidth];
    end
  end

  reqExclusive: assert property (@(posedge bus2ip_clk) disable iff (!rst_n)
    !(ip2busMstRdReq && ip2busMstWrReq));

  reqHeld: assert property (@(posedge bus2ip_clk) disable iff (!rst_n)
    (ip2busMstRdReq || ip2busMstWrReq) && !bus2ipMstCmdack |=>
      $stable({ip2busMstRdReq, ip2busMstWrReq, ip2busMstAddr, ip2busMstBe, ip2busMstWrD}));

endmodule

/* design/ttlIpifBridge.sv */
`timescale 1ns/1ps

module ttlIpifBridge (
  input  logic                                bus2ip_clk,
  input  logic                                rst_n,
  input  logic                                enable,
  // Host side
  input  logic                                nChipEnable,
  input  logic                                nOutputEnable,
  input  logic                                nWriteEnable,
  input  logic [ttlBusPkg::TtlAddrWidth-1:0]  address,
  input  logic [ttlBusPkg::TtlDataWidth-1:0]  dataIn,
  output logic [ttlBusPkg::TtlDataWidth-1:0]  dataOut,
  output logic                                dataOe,
  output logic                                nWait,
  // Master side
  input  logic [mstBusPkg::MstAddrWidth-1:0]  mappedAddress,
  output logic                                ip2busMstRdReq,
  output logic                                ip2busMstWrReq,
  output logic [mstBusPkg::MstAddrWidth-1:0]  ip2busMstAddr,
  output logic [mstBusPkg::MstBeWidth-1:0]    ip2busMstBe,
  output logic [mstBusPkg::MstDataWidth-1:0]  ip2busMstWrD,
  output logic                                ip2busMstReset,
  input  logic                                bus2ipMstCmdack,
  input  logic                                bus2ipMstCmplt,
  input  logic                                bus2ipMstError,
  input  logic [mstBusPkg::MstDataWidth-1:0]  bus2ipMstrdD,
  output logic                                mstError
);
  import ttlBusPkg::*;

  logic cmdPush;
  logic cmdPop;
  logic cmdFull;
  logic cmdEmpty;
  logic [CmdWidth-1:0] cmdIn;
  logic [CmdWidth-1:0] cmdOut;
  logic rdValid;
  logic [TtlDataWidth-1:0] rdData;

  assign ip2busMstReset = ~rst_n;

  ttlBusFrontend frontend_i (
    .bus2ip_clk    (bus2ip_clk),
    .rst_n         (rst_n),
    .enable        (enable),
    .nChipEnable   (nChipEnable),
    .nOutputEnable (nOutputEnable),
    .nWriteEnable  (nWriteEnable),
    .address       (address),
    .dataIn        (dataIn),
    .cmdFull       (cmdFull),
    .rdValid       (rdValid),
    .rdData        (rdData),
    .nWait         (nWait),
    .dataOut       (dataOut),
    .dataOe        (dataOe),
    .cmdPush       (cmdPush),
    .cmdIn         (cmdIn)
  );

  cmdFifo fifo_i (
    .bus2ip_clk (bus2ip_clk),
    .rst_n      (rst_n),
    .cmdPush    (cmdPush),
    .cmdIn      (cmdIn),
    .cmdPop     (cmdPop),
    .cmdOut     (cmdOut),
    .cmdFull    (cmdFull),
    .cmdEmpty   (cmdEmpty)
  );

  ipifMasterEngine engine_i (
    .bus2ip_clk      (bus2ip_clk),
    .rst_n           (rst_n),
    .cmdOut          (cmdOut),
    .cmdEmpty        (cmdEmpty),
    .mappedAddress   (mappedAddress),
    .bus2ipMstCmdack (bus2ipMstCmdack),
    .bus2ipMstCmplt  (bus2ipMstCmplt),
    .bus2ipMstError  (bus2ipMstError),
    .bus2ipMstrdD    (bus2ipMstrdD),
    .cmdPop          (cmdPop),
    .ip2busMstRdReq  (ip2busMstRdReq),
    .ip2busMstWrReq  (ip2busMstWrReq),
    .ip2busMstAddr   (ip2busMstAddr),
    .ip2busMstBe     (ip2busMstBe),
    .ip2busMstWrD    (ip2busMstWrD),
    .rdValid         (rdValid),
    .rdData          (rdData),
    .mstError        (mstError)
  );

endmodule

/* testbench/ipifSlaveModel.sv */
`timescale 1ns/1ps

module ipifSlaveModel (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                rdReq,
  input  logic                                wrReq,
  input  logic [mstBusPkg::MstAddrWidth-1:0]  addr,
  input  logic [mstBusPkg::MstBeWidth-1:0]    be,
  input  logic [mstBusPkg::MstDataWidth-1:0]  wrD,
  input  logic [7:0]                          ackDelay,
  output logic                                cmdack,
  output logic                                cmplt,
  output logic                                error,
  output logic [mstBusPkg::MstDataWidth-1:0]  rdD
);
  logic [31:0] mem [256];
  logic busy;
  logic [7:0] cnt;

  // Every byte of the fill depends on the whole word index
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = {8'(i), ~8'(i), 8'(i) ^ 8'h5A, 8'(i) + 8'h33};
    end
  end

  // Acknowledge and completion share one cycle after the drawn delay
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy   <= 1'b0;
      cmdack <= 1'b0;
      cmplt  <= 1'b0;
      error  <= 1'b0;
    end else begin
      cmdack <= 1'b0;
      cmplt  <= 1'b0;
      error  <= 1'b0;
      if ((rdReq || wrReq) && !cmdack) begin
        if (!busy) begin
          busy <= 1'b1;
          cnt  <= ackDelay;
        end else if (cnt == 8'd0) begin
          busy   <= 1'b0;
          cmdack <= 1'b1;
          cmplt  <= 1'b1;
          error  <= (addr[9:2] == 8'hFF);
          rdD    <= mem[addr[9:2]];
          if (wrReq) begin
            for (int l = 0; l < 4; l++) begin
              if (be[l]) begin
                mem[addr[9:2]][8*l +: 8] <= wrD[8*l +: 8];
              end
            end
          end
        end else begin
          cnt <= cnt - 8'd1;
        end
      end
    end
  end

endmodule

/* testbench/ttlIpifBridgeTb.sv */
`timescale 1ns/1ps

module ttlIpifBridgeTb;
  localparam int NumTests = 6;

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  logic enable = 1'b1;
  logic nChipEnable = 1'b1;
  logic nOutputEnable = 1'b1;
  logic nWriteEnable = 1'b1;
  logic [15:0] address = '0;
  logic [7:0] dataIn = '0;
  logic [7:0] dataOut;
  logic dataOe;
  logic nWait;
  logic [31:0] mappedAddress = 32'h4000_0000;
  logic rdReq;
  logic wrReq;
  logic [31:0] mstAddr;
  logic [3:0] mstBe;
  logic [31:0] mstWrD;
  logic mstReset;
  logic cmdack;
  logic cmplt;
  logic slvError;
  logic [31:0] slvRdD;
  logic mstError;
  logic [7:0] ackDelay = '0;

  logic [31:0] lfsrState = 32'h5947;
  logic slow = 1'b0;
  logic quiet = 1'b0;
  logic stallSeen = 1'b0;
  logic reqPrev = 1'b0;
  logic [15:0] expAddr;
  logic expOp;
  logic [7:0] expData;
  logic [3:0] expBe;
  logic [31:0] expWrD;
  logic [15:0] expAddrQ[$];
  logic expOpQ[$];
  logic [7:0] expDataQ[$];
  logic [7:0] shadow [int];
  string curTest;
  int errCount = 0;
  int errAtStart;
  int passCount = 0;
  int failCount = 0;

  ttlIpifBridge dut_i (
    .bus2ip_clk (clk), .rst_n (rst_n), .enable (enable),
    .nChipEnable (nChipEnable), .nOutputEnable (nOutputEnable),
    .nWriteEnable (nWriteEnable), .address (address), .dataIn (dataIn),
    .dataOut (dataOut), .dataOe (dataOe), .nWait (nWait),
    .mappedAddress (mappedAddress), .ip2busMstRdReq (rdReq),
    .ip2busMstWrReq (wrReq), .ip2busMstAddr (mstAddr), .ip2busMstBe (mstBe),
    .ip2busMstWrD (mstWrD), .ip2busMstReset (mstReset),
    .bus2ipMstCmdack (cmdack), .bus2ipMstCmplt (cmplt),
    .bus2ipMstError (slvError), .bus2ipMstrdD (slvRdD), .mstError (mstError)
  );

  ipifSlaveModel slave_i (
    .clk (clk), .rst_n (rst_n), .rdReq (rdReq), .wrReq (wrReq),
    .addr (mstAddr), .be (mstBe), .wrD (mstWrD), .ackDelay (ackDelay),
    .cmdack (cmdack), .cmplt (cmplt), .error (slvError), .rdD (slvRdD)
  );

  always #2 clk = ~clk;

  task automatic valueErr(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("ERR %s %s: expected %0h, actual %0h", curTest, what, exp, act);
    errCount++;
  endtask

  task automatic plainErr(input string msg);
    $display("%s: %s", curTest, msg);
    errCount++;
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] drawBits(input int n);
    logic [31:0] v;
    logic lsb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lsb = lfsrState[0];
      lfsrState = lfsrState >> 1;
      if (lsb) begin
        lfsrState = lfsrState ^ 32'h8020_0003;
      end
      v = {v[30:0], lsb};
    end
    return v;
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic expectAccess(input logic [15:0] a, input logic op, input logic [7:0] d);
    if (enable) begin
      expAddrQ.push_back(a);
      expOpQ.push_back(op);
      expDataQ.push_back(d);
    end
  endtask

  // Three cycles cover synchronization and the registered push
  task automatic hostWrite(input logic [15:0] a, input logic [7:0] d);
    tick();
    address = a;
    dataIn = d;
    nChipEnable = 1'b0;
    nWriteEnable = 1'b0;
    expectAccess(a, 1'b1, d);
    if (enable) begin
      shadow[a] = d;
    end
    repeat (3) tick();
    while (!nWait) begin
      stallSeen = 1'b1;
      tick();
    end
    nChipEnable = 1'b1;
    nWriteEnable = 1'b1;
    repeat (3) tick();
  endtask

  task automatic checkRead(input logic [15:0] a);
    logic [7:0] got;
    logic oe;
    tick();
    address = a;
    nChipEnable = 1'b0;
    nOutputEnable = 1'b0;
    expectAccess(a, 1'b0, 8'h00);
    repeat (3) tick();
    while (!nWait) begin
      tick();
    end
    got = dataOut;
    oe = dataOe;
    nChipEnable = 1'b1;
    nOutputEnable = 1'b1;
    repeat (3) tick();
    if (enable) begin
      assert (oe) else plainErr("dataOe low while read data is returned");
      assert (got == shadow[a]) else valueErr("read data", shadow[a], got);
    end
  endtask

  // Master request checks against the host access queue
  always @(negedge clk) begin
    if (rst_n && (rdReq || wrReq) && !reqPrev) begin
      if (expAddrQ.size() == 0) begin
        plainErr("master request without a host access");
      end else begin
        expAddr = expAddrQ.pop_front();
        expOp = expOpQ.pop_front();
        expData = expDataQ.pop_front();
        if (slow) begin
          ackDelay = 8'd100;
        end else begin
          ackDelay = 8'(drawBits(2));
        end
        // Only the lane picked by the two low address bits carries the byte
        expBe = '0;
        expWrD = '0;
        for (int l = 0; l < 4; l++) begin
          if (l == int'(expAddr[1:0])) begin
            expBe[l] = 1'b1;
            expWrD[8*l +: 8] = expData;
          end
        end
        assert (mstAddr == mappedAddress + 32'(expAddr))
          else valueErr("address", mappedAddress + 32'(expAddr), mstAddr);
        assert (mstBe == expBe)
          else valueErr("byte enable", expBe, mstBe);
        assert (wrReq == expOp) else valueErr("write request", expOp, wrReq);
        if (expOp) begin
          assert (mstWrD == expWrD)
            else valueErr("write lanes", expWrD, mstWrD);
        end
      end
    end
    reqPrev = rdReq || wrReq;
  end

  errorSticky: assert property (@(negedge clk) disable iff (!rst_n) mstError |=> mstError)
    else begin
      $display("%s: mstError dropped without reset", curTest);
      errCount++;
    end

  disabledQuiet: assert property (@(negedge clk) disable iff (!rst_n)
    quiet |-> nWait && !rdReq && !wrReq)
    else begin
      $display("%s: bridge reacted to the host while disabled", curTest);
      errCount++;
    end

  // The master bus reset mirrors the bridge reset with the opposite sense
  resetBridged: assert property (@(negedge clk) mstReset == !rst_n)
    else begin
      $display("%s: ip2busMstReset does not follow rst_n", curTest);
      errCount++;
    end

  task automatic startTest(input string name);
    curTest = name;
    errAtStart = errCount;
  endtask

  task automatic endTest();
    if (errCount == errAtStart) begin
      $display("test %s: ok", curTest);
      passCount++;
    end else begin
      $display("test %s: failed", curTest);
      failCount++;
    end
  endtask

  initial begin
    #(NumTests * 2000);
    $display("Timeout: the tests did not finish within %0d ns", NumTests * 2000);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [15:0] a;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    tick();

    startTest("writeRead");
    for (int i = 0; i < 8; i++) begin
      r = drawBits(10);
      a = 16'(r[9:0]);
      // Keep clear of the slave's error word
      if (a[9:2] == 8'hFF) begin
        a[9] = 1'b0;
      end
      r = drawBits(8);
      hostWrite(a, r[7:0]);
      checkRead(a);
    end
    endTest();

    startTest("addrMap");
    mappedAddress = 32'h0001_0100;
    for (int i = 0; i < 4; i++) begin
      hostWrite(16'h0020 + 16'(i * 5), 8'hC0 + 8'(i));
      checkRead(16'h0020 + 16'(i * 5));
    end
    mappedAddress = 32'h4000_0000;
    endTest();

    startTest("laneData");
    for (int l = 0; l < 4; l++) begin
      hostWrite(16'h0140 + 16'(l), 8'h11 * 8'(l + 1));
    end
    for (int l = 0; l < 4; l++) begin
      checkRead(16'h0140 + 16'(l));
    end
    endTest();

    startTest("fifoStall");
    slow = 1'b1;
    stallSeen = 1'b0;
    for (int i = 0; i < 6; i++) begin
      hostWrite(16'h0200 + 16'(4 * i + i % 4), 8'hA0 + 8'(i));
    end
    slow = 1'b0;
    assert (stallSeen) else plainErr("nWait never went low with the FIFO full");
    for (int i = 0; i < 6; i++) begin
      checkRead(16'h0200 + 16'(4 * i + i % 4));
    end
    endTest();

    startTest("disabled");
    enable = 1'b0;
    quiet = 1'b1;
    hostWrite(16'h0300, 8'h5C);
    checkRead(16'h0300);
    quiet = 1'b0;
    enable = 1'b1;
    endTest();

    startTest("mstError");
    assert (!mstError) else valueErr("mstError before fault", 1'b0, mstError);
    hostWrite(16'h03FD, 8'hEE);
    checkRead(16'h0140);
    assert (mstError) else valueErr("mstError after fault", 1'b1, mstError);
    hostWrite(16'h0041, 8'h77);
    checkRead(16'h0041);
    assert (mstError) else valueErr("mstError later", 1'b1, mstError);
    endTest();

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             NumTests, passCount, failCount, errCount);
    if (errCount == 0 && failCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* src.f */
design/ttlBusPkg.sv
design/mstBusPkg.sv
design/ttlBusFrontend.sv
design/cmdFifo.sv
design/ipifMasterEngine.sv
design/ttlIpifBridge.sv
testbench/ipifSlaveModel.sv
testbench/ttlIpifBridgeTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ttlIpifBridgeTb
BUILD     ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
